// File: sim.f
design/isa_pkg.sv
design/ctrl_pkg.sv
design/control_unit.sv
design/stage_regs.sv
design/alu.sv
design/reg_file.sv
design/data_mem.sv
design/pipe_core.sv
sim/pipe_core_properties.sv
sim/pipe_core_tb.sv

// File: Bender.yml
package:
  name: pipe_core

sources:
  - design/isa_pkg.sv
  - design/ctrl_pkg.sv
  - design/control_unit.sv
  - design/stage_regs.sv
  - design/alu.sv
  - design/reg_file.sv
  - design/data_mem.sv
  - design/pipe_core.sv
  - target: simulation
    files:
      - sim/pipe_core_properties.sv
      - sim/pipe_core_tb.sv

// File: sim/pipe_core_tb.sv
`timescale 1ns/1ps

module pipe_core_tb import isa_pkg::*, ctrl_pkg::*; ();

    localparam int CLK_NS    = 4;
    localparam int RESET_CYC = 10;
    localparam int MEM_DEPTH = 256;
    localparam int AW        = $clog2(MEM_DEPTH);
    localparam int N_ALU     = 36;
    localparam int N_STACK   = 24;
    // Moves, refill, ALU, carry/JC, store/load, stack worst case, JZ/JN
    localparam int N_INSTR   = 32 + 8 + 3 * N_ALU + 24 + 40 + 4 * N_STACK + 60;

    typedef struct packed {
        logic [31:0]       issue_cyc;
        logic              out_v;
        logic [DATA_W-1:0] out_d;
        logic              jmp;
        logic [DATA_W-1:0] tgt;
        logic [FLAG_W-1:0] flg;
    } expect_t;

    logic              clk;
    logic              rst_n;
    instr_u            instr;
    logic [DATA_W-1:0] in_port;
    logic [DATA_W-1:0] out_port;
    logic              out_strobe;
    logic              jump_taken;
    logic [DATA_W-1:0] jump_target;
    logic [FLAG_W-1:0] flags;

    integer      seed = 32'hb5c6_d922;
    int unsigned cyc  = 0;   // Rising edges seen so far
    expect_t     exp_q [$];

    // Reference machine state
    logic [DATA_W-1:0] m_regs [8] = '{default: '0};
    logic [DATA_W-1:0] m_mem [MEM_DEPTH];
    logic [AW-1:0]     m_sp    = AW'(MEM_DEPTH - 1);
    logic [FLAG_W-1:0] m_flags = '0;
    logic [4:0]        alu_ops [9] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT,
                                       OP_INC, OP_DEC, OP_SHL, OP_SHR};

    pipe_core #(.MEM_DEPTH(MEM_DEPTH)) pipe_core_inst (
        .clk, .rst_n, .instr, .in_port, .out_port, .out_strobe,
        .jump_taken, .jump_target, .flags
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    function automatic expect_t model_step(input instr_u ins, input logic [DATA_W-1:0] in_val);
        expect_t           e;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] res;
        logic              wr;
        logic              zn;
        e   = '0;
        a   = m_regs[ins.reg_fmt.rdst];
        b   = m_regs[ins.reg_fmt.rsrc];
        res = '0;
        wr  = 1'b1;   // Most opcodes write rdst
        zn  = ins.reg_fmt.opcode inside {OP_NOT, OP_INC, OP_DEC, OP_ADD, OP_SUB,
                                         OP_AND, OP_OR, OP_SHL, OP_SHR};
        case (ins.reg_fmt.opcode)
            OP_NOT:  res = ~a;
            OP_INC:  res = a + 16'd1;
            OP_DEC:  res = a - 16'd1;
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_SHL:  res = a << ins.imm_fmt.imm[3:0];
            OP_SHR:  res = a >> ins.imm_fmt.imm[3:0];
            OP_MOV:  res = b;
            OP_LDM:  res = DATA_W'(ins.imm_fmt.imm);
            OP_IN:   res = in_val;
            OP_LOAD: res = m_mem[b[AW-1:0]];
            OP_POP: begin
                m_sp = m_sp + 1'b1;   // Increment first, then read
                res  = m_mem[m_sp];
            end
            default: wr = 1'b0;
        endcase
        case (ins.reg_fmt.opcode)
            OP_SETC:  m_flags[FLAG_C] = 1'b1;
            OP_CLRC:  m_flags[FLAG_C] = 1'b0;
            OP_INC:   m_flags[FLAG_C] = (a == 16'hffff);
            OP_ADD:   m_flags[FLAG_C] = (32'(a) + 32'(b) > 32'hffff);
            OP_DEC:   m_flags[FLAG_C] = (a == 16'd0);   // Borrow
            OP_SUB:   m_flags[FLAG_C] = (a < b);
            OP_STORE: m_mem[b[AW-1:0]] = a;
            OP_PUSH: begin
                m_mem[m_sp] = a;
                m_sp        = m_sp - 1'b1;
            end
            OP_OUT: begin
                e.out_v = 1'b1;
                e.out_d = a;
            end
            OP_JZ:    e.jmp = m_flags[FLAG_Z];
            OP_JN:    e.jmp = m_flags[FLAG_N];
            OP_JC:    e.jmp = m_flags[FLAG_C];
            default:  ;
        endcase
        if (zn) begin
            m_flags[FLAG_Z] = (res == 16'd0);
            m_flags[FLAG_N] = res[DATA_W-1];
        end
        if (wr)
            m_regs[ins.reg_fmt.rdst] = res;
        e.tgt = a;
        e.flg = m_flags;
        return e;
    endfunction

    task automatic stop_on_failure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] act,
                              input logic [DATA_W-1:0] exp);
        if (act !== exp) begin
            $display("[FAIL] %0t ns: %s expected %h, got %h", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_flags(input string name, input logic [FLAG_W-1:0] act,
                               input logic [FLAG_W-1:0] exp);
        if (act !== exp) begin
            $display("[FAIL] %0t ns: %s expected %b, got %b", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("[FAIL] %0t ns: %s expected %b, got %b", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    // One instruction, then three NOPs
    task automatic issue(input logic [4:0] op, input logic [2:0] rd, input logic [7:0] low,
                         input logic [DATA_W-1:0] in_val);
        instr_u  ins;
        expect_t e;
        ins = {op, rd, low};
        @(posedge clk);
        #1;
        e           = model_step(ins, in_val);
        e.issue_cyc = cyc;
        exp_q.push_back(e);
        instr   = ins;
        in_port = in_val;   // Held until the next instruction
        repeat (3) begin
            @(posedge clk);
            #1;
            instr = '0;
        end
    endtask

    task automatic issue_reg(input logic [4:0] op, input logic [2:0] rd, input logic [2:0] rs);
        issue(op, rd, {rs, 5'd0}, in_port);
    endtask

    task automatic issue_imm(input logic [4:0] op, input logic [2:0] rd, input logic [7:0] imm);
        issue(op, rd, imm, in_port);
    endtask

    // Jump and flags at issue+3, OUT at issue+4
    initial begin
        expect_t           e;
        logic [FLAG_W-1:0] cur_flags;
        cur_flags = '0;
        forever begin
            @(negedge clk);
            if (pipe_core_inst.pipe_core_properties_inst.assert_fails != 0) begin
                $display("An assertion in pipe_core_properties failed at %0t ns", $time);
                stop_on_failure();
            end
            if (exp_q.size() != 0 && cyc == exp_q[0].issue_cyc + 3) begin
                e = exp_q[0];
                check_bit("jump_taken", jump_taken, e.jmp);
                if (e.jmp)
                    check_data("jump_target", jump_target, e.tgt);
                check_bit("out_strobe", out_strobe, 1'b0);
                cur_flags = e.flg;
            end else if (exp_q.size() != 0 && cyc == exp_q[0].issue_cyc + 4) begin
                e = exp_q.pop_front();
                check_bit("out_strobe", out_strobe, e.out_v);
                if (e.out_v)
                    check_data("out_port", out_port, e.out_d);
                check_bit("jump_taken", jump_taken, 1'b0);
            end else begin
                check_bit("jump_taken", jump_taken, 1'b0);
                check_bit("out_strobe", out_strobe, 1'b0);
            end
            check_flags("flags", flags, cur_flags);
        end
    end

    initial begin
        #((N_INSTR * 4 + RESET_CYC + 50) * CLK_NS);
        $display("Timeout: the instruction sequence did not complete in time");
        stop_on_failure();
    end

    initial begin
        int         depth;
        logic [7:0] v;
        logic [7:0] w;
        rst_n   = 1'b0;
        instr   = '0;
        in_port = '0;
        depth   = 0;
        repeat (RESET_CYC) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int r = 0; r < 8; r++) begin
            issue_imm(OP_LDM, 3'(r), 8'($random(seed)));
            issue_reg(OP_OUT, 3'(r), 3'd0);
        end
        for (int r = 0; r < 4; r++) begin
            issue(OP_IN, 3'(r), 8'd0, DATA_W'($random(seed)));
            issue_reg(OP_OUT, 3'(r), 3'd0);
        end
        for (int r = 0; r < 4; r++) begin
            issue_reg(OP_MOV, 3'(r + 4), 3'(r));
            issue_reg(OP_OUT, 3'(r + 4), 3'd0);
        end

        for (int r = 0; r < 8; r++)
            issue(OP_IN, 3'(r), 8'd0, DATA_W'($random(seed)));
        for (int i = 0; i < N_ALU; i++) begin
            v = 8'($random(seed));   // Register pick for the refresh and the op
            issue(OP_IN, v[2:0], 8'd0, DATA_W'($random(seed)));
            issue(alu_ops[$unsigned($random(seed)) % 9], v[5:3], 8'($random(seed)), in_port);
            issue_reg(OP_OUT, v[5:3], 3'd0);
        end

        for (int i = 0; i < 8; i++) begin
            issue_reg(($random(seed) & 1) ? OP_SETC : OP_CLRC, 3'd0, 3'd0);
            issue_reg(OP_MOV, 3'd1, 3'(i));
            issue_reg(OP_JC, 3'(i), 3'd0);
        end

        for (int i = 0; i < 8; i++) begin
            issue(OP_IN, 3'd1, 8'd0, DATA_W'($random(seed)));
            issue_imm(OP_LDM, 3'd2, 8'($random(seed)));
            issue_reg(OP_STORE, 3'd1, 3'd2);
            issue_reg(OP_LOAD, 3'd3, 3'd2);
            issue_reg(OP_OUT, 3'd3, 3'd0);
        end

        for (int i = 0; i < N_STACK; i++) begin
            if (depth == 0 || ($random(seed) & 1)) begin
                issue(OP_IN, 3'd4, 8'd0, DATA_W'($random(seed)));
                issue_reg(OP_PUSH, 3'd4, 3'd0);
                depth++;
            end else begin
                issue_reg(OP_POP, 3'd5, 3'd0);
                issue_reg(OP_OUT, 3'd5, 3'd0);
                depth--;
            end
        end
        while (depth > 0) begin
            issue_reg(OP_POP, 3'd5, 3'd0);
            issue_reg(OP_OUT, 3'd5, 3'd0);
            depth--;
        end

        for (int i = 0; i < 12; i++) begin
            v = 8'($random(seed));
            w = ($random(seed) & 1) ? v : 8'($random(seed));   // Equal half the time
            issue_imm(OP_LDM, 3'd6, v);
            issue_imm(OP_LDM, 3'd7, w);
            issue_reg(OP_SUB, 3'd6, 3'd7);
            issue_reg(OP_JZ, 3'($random(seed)), 3'd0);
            issue_reg(OP_JN, 3'($random(seed)), 3'd0);
        end

        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (2) @(posedge clk);
        if (pipe_core_inst.pipe_core_properties_inst.assert_fails == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("An assertion in pipe_core_properties failed");
            stop_on_failure();
        end
    end

endmodule

// File: sim/pipe_core_properties.sv
`timescale 1ns/1ps

module pipe_core_properties (
    input logic        clk,
    input logic        rst_n,
    input logic [15:0] instr,
    input logic        out_strobe,
    input logic        jump_taken,
    input logic        mem_read,
    input logic        mem_write
);

    int   assert_fails = 0;
    logic seen_instr;   // Any non-NOP since reset

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            seen_instr <= 1'b0;
        else if (instr != 16'd0)
            seen_instr <= 1'b1;
    end

    // Every instruction is padded by NOPs, so each strobe lasts one cycle
    single_strobes: assert property (@(posedge clk) disable iff (!rst_n)
        !(out_strobe && $past(out_strobe)) && !(jump_taken && $past(jump_taken)))
    else begin
        $error("out_strobe or jump_taken high in two consecutive cycles");
        assert_fails++;
    end

    no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
    else begin
        $error("mem_read and mem_write high together");
        assert_fails++;
    end

    quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_instr |-> !jump_taken)
    else begin
        $error("jump_taken high before any instruction arrived");
        assert_fails++;
    end

endmodule

bind pipe_core pipe_core_properties pipe_core_properties_inst (
    .clk, .rst_n, .instr, .out_strobe, .jump_taken, .mem_read, .mem_write
);

// File: design/pipe_core.sv
`timescale 1ns/1ps

module pipe_core import isa_pkg::*; #(
    parameter int MEM_DEPTH = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  instr_u            instr,
    input  logic [DATA_W-1:0] in_port,
    output logic [DATA_W-1:0] out_port,
    output logic              out_strobe,
    output logic              jump_taken,
    output logic [DATA_W-1:0] jump_target,
    output logic [2:0]        flags
);

    logic [3:0]            alu_op, ex_op, ex_shamt;
    logic                  id_mem_read, id_mem_write, wb, id_push, id_pop;
    logic                  in_sel, out_en, imm_sel, one_operand;
    logic [1:0]            jump_type;
    logic [REG_ADDR_W-1:0] rdst, rsrc, wb_addr;
    logic [IMM_W-1:0]      imm;
    logic [DATA_W-1:0]     rd_a, rd_b, ex_a, ex_b, alu_result;
    logic [DATA_W-1:0]     mem_addr, mem_wdata, mem_rdata, wb_data;
    logic                  mem_read, mem_write, push, pop, wb_en, flag_we;
    logic [2:0]            alu_flags_next;

    control_unit control_unit_inst (
        .clk, .rst_n, .instr, .alu_op, .mem_read(id_mem_read), .mem_write(id_mem_write),
        .wb, .push(id_push), .pop(id_pop), .in_sel, .out_en, .imm_sel, .one_operand,
        .jump_type, .rdst, .rsrc, .imm
    );

    stage_regs stage_regs_inst (
        .clk, .rst_n, .id_alu_op(alu_op), .id_mem_read, .id_mem_write, .id_wb(wb),
        .id_push, .id_pop, .id_in_sel(in_sel), .id_out_en(out_en), .id_imm_sel(imm_sel),
        .id_one_operand(one_operand), .id_jump_type(jump_type), .id_rdst(rdst),
        .id_imm(imm), .rd_a, .rd_b, .in_port, .alu_result, .alu_flags_next, .flags,
        .mem_rdata, .ex_op, .ex_a, .ex_b, .ex_shamt, .mem_addr, .mem_wdata, .mem_read,
        .mem_write, .push, .pop, .wb_en, .wb_addr, .wb_data, .out_port, .out_strobe,
        .jump_taken, .jump_target, .flag_we
    );

    alu alu_inst (
        .clk, .rst_n, .ex_op, .ex_a, .ex_b, .ex_shamt, .flag_we,
        .alu_result, .alu_flags_next, .flags
    );

    reg_file reg_file_inst (
        .clk, .rst_n, .rd_addr_a(rdst), .rd_addr_b(rsrc),
        .wb_en, .wb_addr, .wb_data, .rd_a, .rd_b
    );

    data_mem #(.MEM_DEPTH(MEM_DEPTH)) data_mem_inst (
        .clk, .rst_n, .mem_addr, .mem_wdata, .mem_read, .mem_write, .push, .pop, .mem_rdata
    );

endmodule

// File: design/data_mem.sv
`timescale 1ns/1ps

module data_mem #(
    parameter int MEM_DEPTH = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] mem_addr,
    input  logic [15:0] mem_wdata,
    input  logic        mem_read,
    input  logic        mem_write,
    input  logic        push,
    input  logic        pop,
    output logic [15:0] mem_rdata
);

    localparam int AW = $clog2(MEM_DEPTH);

    logic [15:0]   mem [MEM_DEPTH];
    logic [AW-1:0] sp;
    logic [AW-1:0] rd_idx;

    assign rd_idx    = pop ? sp + 1'b1 : mem_addr[AW-1:0];   // Pop reads above sp
    assign mem_rdata = (mem_read || pop) ? mem[rd_idx] : 16'd0;

    always_ff @(posedge clk) begin
        if (mem_write)
            mem[mem_addr[AW-1:0]] <= mem_wdata;
        else if (push)
            mem[sp] <= mem_wdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sp <= AW'(MEM_DEPTH - 1);
        else if (push)
            sp <= sp - 1'b1;
        else if (pop)
            sp <= sp + 1'b1;
    end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [2:0]  rd_addr_a,
    input  logic [2:0]  rd_addr_b,
    input  logic        wb_en,
    input  logic [2:0]  wb_addr,
    input  logic [15:0] wb_data,
    output logic [15:0] rd_a,
    output logic [15:0] rd_b
);

    logic [15:0] regs [8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            regs <= '{default: '0};
        else if (wb_en)
            regs[wb_addr] <= wb_data;
    end

    // No bypass, a write shows up the cycle after the edge
    assign rd_a = regs[rd_addr_a];
    assign rd_b = regs[rd_addr_b];

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu import ctrl_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [3:0]        ex_op,
    input  logic [15:0]       ex_a,
    input  logic [15:0]       ex_b,
    input  logic [3:0]        ex_shamt,
    input  logic              flag_we,
    output logic [15:0]       alu_result,
    output logic [FLAG_W-1:0] alu_flags_next,
    output logic [FLAG_W-1:0] flags
);

    logic [16:0] sum;   // Bit 16 is carry or borrow
    logic        set_zn;

    always_comb begin
        sum            = {1'b0, ex_a} + {1'b0, ex_b};
        alu_result     = ex_b;
        alu_flags_next = flags;
        set_zn         = 1'b1;
        case (ex_op)
            ALU_NOT: alu_result = ~ex_a;
            ALU_INC, ALU_ADD: begin
                alu_result             = sum[15:0];
                alu_flags_next[FLAG_C] = sum[16];
            end
            ALU_DEC, ALU_SUB: begin
                sum                    = {1'b0, ex_a} - {1'b0, ex_b};
                alu_result             = sum[15:0];
                alu_flags_next[FLAG_C] = sum[16];
            end
            ALU_AND: alu_result = ex_a & ex_b;
            ALU_OR:  alu_result = ex_a | ex_b;
            ALU_SHL: alu_result = ex_a << ex_shamt;
            ALU_SHR: alu_result = ex_a >> ex_shamt;
            ALU_SETC: begin
                alu_flags_next[FLAG_C] = 1'b1;
                set_zn                 = 1'b0;
            end
            ALU_CLRC: begin
                alu_flags_next[FLAG_C] = 1'b0;
                set_zn                 = 1'b0;
            end
            default: set_zn = 1'b0;   // MOV, PASS and NONE keep flags
        endcase
        if (set_zn) begin
            alu_flags_next[FLAG_Z] = (alu_result == 16'd0);
            alu_flags_next[FLAG_N] = alu_result[15];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            flags <= '0;
        else if (flag_we)
            flags <= alu_flags_next;
    end

endmodule

// File: design/stage_regs.sv
`timescale 1ns/1ps

module stage_regs import isa_pkg::*, ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [3:0]            id_alu_op,
    input  logic                  id_mem_read,
    input  logic                  id_mem_write,
    input  logic                  id_wb,
    input  logic                  id_push,
    input  logic                  id_pop,
    input  logic                  id_in_sel,
    input  logic                  id_out_en,
    input  logic                  id_imm_sel,
    input  logic                  id_one_operand,
    input  logic [1:0]            id_jump_type,
    input  logic [REG_ADDR_W-1:0] id_rdst,
    input  logic [IMM_W-1:0]      id_imm,
    input  logic [DATA_W-1:0]     rd_a,
    input  logic [DATA_W-1:0]     rd_b,
    input  logic [DATA_W-1:0]     in_port,
    input  logic [DATA_W-1:0]     alu_result,
    input  logic [FLAG_W-1:0]     alu_flags_next,
    input  logic [FLAG_W-1:0]     flags,
    input  logic [DATA_W-1:0]     mem_rdata,
    output logic [3:0]            ex_op,
    output logic [DATA_W-1:0]     ex_a,
    output logic [DATA_W-1:0]     ex_b,
    output logic [3:0]            ex_shamt,
    output logic [DATA_W-1:0]     mem_addr,
    output logic [DATA_W-1:0]     mem_wdata,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  push,
    output logic                  pop,
    output logic                  wb_en,
    output logic [REG_ADDR_W-1:0] wb_addr,
    output logic [DATA_W-1:0]     wb_data,
    output logic [DATA_W-1:0]     out_port,
    output logic                  out_strobe,
    output logic                  jump_taken,
    output logic [DATA_W-1:0]     jump_target,
    output logic                  flag_we
);

    logic                  ex_mem_read, ex_mem_write, ex_wb, ex_push, ex_pop, ex_out;
    logic [1:0]            ex_jump;
    logic [REG_ADDR_W-1:0] ex_rdst, mem_rdst;
    logic                  mem_wb, mem_out;
    logic                  ex_take;

    always_comb begin
        case (ex_jump)
            JMP_Z:   ex_take = flags[FLAG_Z];   // Flags from before this instruction
            JMP_N:   ex_take = flags[FLAG_N];
            JMP_C:   ex_take = flags[FLAG_C];
            default: ex_take = 1'b0;
        endcase
    end

    assign flag_we = (alu_flags_next != flags);   // Write only on change

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_op        <= ALU_NONE;
            ex_a         <= '0;
            ex_b         <= '0;
            ex_shamt     <= '0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_wb        <= 1'b0;
            ex_push      <= 1'b0;
            ex_pop       <= 1'b0;
            ex_out       <= 1'b0;
            ex_jump      <= JMP_NONE;
            ex_rdst      <= '0;
            mem_addr     <= '0;
            mem_wdata    <= '0;
            mem_read     <= 1'b0;
            mem_write    <= 1'b0;
            push         <= 1'b0;
            pop          <= 1'b0;
            mem_wb       <= 1'b0;
            mem_out      <= 1'b0;
            mem_rdst     <= '0;
            jump_taken   <= 1'b0;
            jump_target  <= '0;
            wb_en        <= 1'b0;
            wb_addr      <= '0;
            wb_data      <= '0;
            out_strobe   <= 1'b0;
            out_port     <= '0;
        end else begin
            // EX register
            ex_op        <= id_alu_op;
            ex_a         <= rd_a;
            ex_b         <= id_in_sel      ? in_port :
                            id_imm_sel     ? DATA_W'(id_imm) :
                            id_one_operand ? DATA_W'(1) : rd_b;
            ex_shamt     <= id_imm[3:0];
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
            ex_wb        <= id_wb;
            ex_push      <= id_push;
            ex_pop       <= id_pop;
            ex_out       <= id_out_en;
            ex_jump      <= id_jump_type;
            ex_rdst      <= id_rdst;
            // MEM register
            mem_addr     <= alu_result;
            mem_wdata    <= ex_a;   // Store, push and out data
            mem_read     <= ex_mem_read;
            mem_write    <= ex_mem_write;
            push         <= ex_push;
            pop          <= ex_pop;
            mem_wb       <= ex_wb;
            mem_out      <= ex_out;
            mem_rdst     <= ex_rdst;
            jump_taken   <= ex_take;
            jump_target  <= ex_a;
            // WB register
            wb_en        <= mem_wb;
            wb_addr      <= mem_rdst;
            wb_data      <= (mem_read || pop) ? mem_rdata : mem_addr;
            out_strobe   <= mem_out;
            out_port     <= mem_wdata;
        end
    end

endmodule

// File: design/control_unit.sv
`timescale 1ns/1ps

module control_unit import isa_pkg::*, ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  instr_u                instr,
    output logic [3:0]            alu_op,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  wb,
    output logic                  push,
    output logic                  pop,
    output logic                  in_sel,
    output logic                  out_en,
    output logic                  imm_sel,
    output logic                  one_operand,
    output logic [1:0]            jump_type,
    output logic [REG_ADDR_W-1:0] rdst,
    output logic [REG_ADDR_W-1:0] rsrc,
    output logic [IMM_W-1:0]      imm
);

    logic [3:0] alu_op_d;
    logic       mem_read_d, mem_write_d, push_d, pop_d;
    logic       in_d, out_d, imm_d, wb_d;
    logic [1:0] jump_d;

    always_comb begin
        alu_op_d    = ALU_NONE;
        mem_read_d  = 1'b0;
        mem_write_d = 1'b0;
        push_d      = 1'b0;
        pop_d       = 1'b0;
        in_d        = 1'b0;
        out_d       = 1'b0;
        imm_d       = 1'b0;
        jump_d      = JMP_NONE;   // Cleared on every decode
        case (instr.reg_fmt.opcode)
            OP_SETC:  alu_op_d = ALU_SETC;
            OP_CLRC:  alu_op_d = ALU_CLRC;
            OP_NOT:   alu_op_d = ALU_NOT;
            OP_INC:   alu_op_d = ALU_INC;
            OP_DEC:   alu_op_d = ALU_DEC;
            OP_IN: begin
                alu_op_d = ALU_PASS;   // in_port rides the B operand
                in_d     = 1'b1;
            end
            OP_OUT:   out_d  = 1'b1;
            OP_PUSH:  push_d = 1'b1;
            OP_POP:   pop_d  = 1'b1;
            OP_LOAD: begin
                alu_op_d   = ALU_PASS;   // Address from rsrc
                mem_read_d = 1'b1;
            end
            OP_STORE: begin
                alu_op_d    = ALU_PASS;
                mem_write_d = 1'b1;
            end
            OP_LDM: begin
                alu_op_d = ALU_PASS;
                imm_d    = 1'b1;
            end
            OP_MOV:   alu_op_d = ALU_MOV;
            OP_ADD:   alu_op_d = ALU_ADD;
            OP_SUB:   alu_op_d = ALU_SUB;
            OP_AND:   alu_op_d = ALU_AND;
            OP_OR:    alu_op_d = ALU_OR;
            OP_SHL: begin
                alu_op_d = ALU_SHL;
                imm_d    = 1'b1;
            end
            OP_SHR: begin
                alu_op_d = ALU_SHR;
                imm_d    = 1'b1;
            end
            OP_JZ:    jump_d = JMP_Z;
            OP_JN:    jump_d = JMP_N;
            OP_JC:    jump_d = JMP_C;
            default:  ;   // NOP and unused opcodes
        endcase
        wb_d = ((alu_op_d != ALU_NONE && alu_op_d != ALU_SETC && alu_op_d != ALU_CLRC)
                || mem_read_d || pop_d) && !mem_write_d;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_op      <= ALU_NONE;
            mem_read    <= 1'b0;
            mem_write   <= 1'b0;
            wb          <= 1'b0;
            push        <= 1'b0;
            pop         <= 1'b0;
            in_sel      <= 1'b0;
            out_en      <= 1'b0;
            imm_sel     <= 1'b0;
            one_operand <= 1'b0;
            jump_type   <= JMP_NONE;
            rdst        <= '0;
            rsrc        <= '0;
            imm         <= '0;
        end else begin
            alu_op      <= alu_op_d;
            mem_read    <= mem_read_d;
            mem_write   <= mem_write_d;
            wb          <= wb_d;
            push        <= push_d;
            pop         <= pop_d;
            in_sel      <= in_d;
            out_en      <= out_d;
            imm_sel     <= imm_d;
            one_operand <= (alu_op_d == ALU_NOT) || (alu_op_d == ALU_INC)
                           || (alu_op_d == ALU_DEC);
            jump_type   <= jump_d;
            rdst        <= instr.reg_fmt.rdst;
            rsrc        <= instr.reg_fmt.rsrc;
            imm         <= instr.imm_fmt.imm;
        end
    end

endmodule

// File: design/ctrl_pkg.sv
package ctrl_pkg;

    localparam logic [3:0] ALU_NONE = 4'd0;
    localparam logic [3:0] ALU_NOT  = 4'd1;
    localparam logic [3:0] ALU_INC  = 4'd2;
    localparam logic [3:0] ALU_DEC  = 4'd3;
    localparam logic [3:0] ALU_MOV  = 4'd4;
    localparam logic [3:0] ALU_ADD  = 4'd5;
    localparam logic [3:0] ALU_SUB  = 4'd6;
    localparam logic [3:0] ALU_AND  = 4'd7;
    localparam logic [3:0] ALU_OR   = 4'd8;
    localparam logic [3:0] ALU_SHL  = 4'd9;
    localparam logic [3:0] ALU_SHR  = 4'd10;
    localparam logic [3:0] ALU_SETC = 4'd11;
    localparam logic [3:0] ALU_CLRC = 4'd12;
    localparam logic [3:0] ALU_PASS = 4'd13;   // Source operand straight through

    localparam logic [1:0] JMP_NONE = 2'd0;
    localparam logic [1:0] JMP_Z    = 2'd1;
    localparam logic [1:0] JMP_N    = 2'd2;
    localparam logic [1:0] JMP_C    = 2'd3;

    localparam int FLAG_W = 3;
    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 2;

endpackage

// File: design/isa_pkg.sv
package isa_pkg;

    localparam int DATA_W     = 16;
    localparam int REG_ADDR_W = 3;
    localparam int OPCODE_W   = 5;
    localparam int IMM_W      = 8;

    localparam logic [OPCODE_W-1:0] OP_NOP   = 5'd0;
    localparam logic [OPCODE_W-1:0] OP_SETC  = 5'd1;
    localparam logic [OPCODE_W-1:0] OP_CLRC  = 5'd2;
    localparam logic [OPCODE_W-1:0] OP_NOT   = 5'd3;
    localparam logic [OPCODE_W-1:0] OP_INC   = 5'd4;
    localparam logic [OPCODE_W-1:0] OP_DEC   = 5'd5;
    localparam logic [OPCODE_W-1:0] OP_IN    = 5'd6;
    localparam logic [OPCODE_W-1:0] OP_OUT   = 5'd7;
    localparam logic [OPCODE_W-1:0] OP_PUSH  = 5'd8;
    localparam logic [OPCODE_W-1:0] OP_POP   = 5'd9;
    localparam logic [OPCODE_W-1:0] OP_LOAD  = 5'd10;
    localparam logic [OPCODE_W-1:0] OP_STORE = 5'd12;
    localparam logic [OPCODE_W-1:0] OP_LDM   = 5'd13;
    localparam logic [OPCODE_W-1:0] OP_JZ    = 5'd16;
    localparam logic [OPCODE_W-1:0] OP_JN    = 5'd17;
    localparam logic [OPCODE_W-1:0] OP_JC    = 5'd18;
    localparam logic [OPCODE_W-1:0] OP_MOV   = 5'd24;
    localparam logic [OPCODE_W-1:0] OP_ADD   = 5'd25;
    localparam logic [OPCODE_W-1:0] OP_SUB   = 5'd26;
    localparam logic [OPCODE_W-1:0] OP_AND   = 5'd28;
    localparam logic [OPCODE_W-1:0] OP_OR    = 5'd29;
    localparam logic [OPCODE_W-1:0] OP_SHL   = 5'd30;
    localparam logic [OPCODE_W-1:0] OP_SHR   = 5'd31;

    // Same 16-bit word, register form or immediate form
    typedef union packed {
        struct packed {
            logic [OPCODE_W-1:0]   opcode;
            logic [REG_ADDR_W-1:0] rdst;
            logic [REG_ADDR_W-1:0] rsrc;
            logic [4:0]            unused;
        } reg_fmt;
        struct packed {
            logic [OPCODE_W-1:0]   opcode;
            logic [REG_ADDR_W-1:0] rdst;
            logic [IMM_W-1:0]      imm;   // LDM value, low nibble is shift amount
        } imm_fmt;
    } instr_u;

endpackage
